// ==== files.f ====
verilog/spi_pkg.sv
verilog/spi_wb_regs.sv
verilog/spi_clk_div.sv
verilog/spi_shift_engine.sv
verilog/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// ==== Makefile ====
# Verilator build and run of the SPI master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SOURCES   := $(wildcard verilog/*.sv) $(wildcard verification/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the result"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_spi_master.sv ====
`timescale 1ns/1ps

module tb_spi_master;
	import spi_pkg::*;

	localparam int NUM_SS    = 4;
	localparam int SLAVE_IDX = 2;
	localparam int NUM_XFERS = 9;
	localparam int MAX_CLKS  = (2 * 32 + 1) * 4 + 1 + 60; // 32 bits at prescale 3, plus bus traffic
	localparam logic [NUM_SS-1:0] SS_SEL = ~(NUM_SS'(1) << SLAVE_IDX);

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [SPI_ADDR_W-1:0] wb_adr;
	logic [31:0]           wb_dat_i;
	logic [3:0]            wb_sel;
	logic [31:0]           wb_dat_o;
	logic                  wb_ack;
	logic                  sck;
	logic                  mosi;
	logic                  miso;
	logic [NUM_SS-1:0]     ss;

	// Slave setup, same mode as the CTRL word
	logic        s_cpol = 1'b0;
	logic        s_cpha = 1'b0;
	logic        s_lsb = 1'b0;
	logic [5:0]  s_bits = 6'd8;
	logic [31:0] s_reply = '0;
	logic [31:0] s_rx;

	int          errors = 0;
	int          checks = 0;
	int          cyc_cnt = 0;
	int          start_cyc = 0; // Cycle of the start pulse
	int          xfers_seen = 0;
	int          cur_presc = 0;
	int          cur_bits = 8;
	int          gap = 0; // Clocks since the last ss or sck event
	int          edges = 0;
	logic        cur_cpol = 1'b0;
	logic        prev_ss = 1'b1;
	logic        prev_sck = 1'b0;
	logic [31:0] lcg_state = 32'h4afefdf2;

	spi_master_top #(.NUM_SS(NUM_SS), .PRESCALE_W(24)) dut (
		.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_sel(wb_sel), .wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack), .sck(sck), .mosi(mosi), .miso(miso), .ss(ss)
	);

	spi_slave_model slave_model (
		.ss_n(ss[SLAVE_IDX]), .sck(sck), .mosi(mosi), .miso(miso), .cpol(s_cpol),
		.cpha(s_cpha), .lsb_first(s_lsb), .bits(s_bits), .reply(s_reply), .rx_word(s_rx)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
		cyc_cnt++;

	// Ack comes one cycle after a new request and lasts one cycle
	a_ack_next: assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else begin
			errors++;
			$display("Bus request was not acked in the following cycle");
		end

	a_ack_once: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else begin
			errors++;
			$display("Ack stayed high for more than one cycle");
		end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [SPI_ADDR_W-1:0] word_adr(input logic [7:0] off);
		return off[SPI_ADDR_W+1:2]; // Byte offset to word index
	endfunction

	task automatic expect_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wb_write(input logic [SPI_ADDR_W-1:0] adr, input logic [31:0] data,
			input logic [3:0] sel);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_i = data;
		wb_sel   = sel;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_read(input logic [SPI_ADDR_W-1:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		data   = wb_dat_o; // Valid in the ack cycle
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// One loopback transfer with random data, reply and a busy-time rejected write
	task automatic run_transfer(input logic cpol, input logic cpha, input logic lsb,
			input logic [1:0] len, input int presc);
		logic [31:0] data;
		logic [31:0] reply;
		logic [31:0] mask;
		logic [31:0] rd;
		int          bits;
		data  = lcg_next();
		reply = lcg_next();
		bits  = (len == 2'd0) ? 8 : (len == 2'd1) ? 16 : 32;
		mask  = (bits == 32) ? 32'hFFFF_FFFF : ((32'h1 << bits) - 1);
		s_cpol  = cpol;
		s_cpha  = cpha;
		s_lsb   = lsb;
		s_bits  = 6'(bits);
		s_reply = reply;
		wb_write(word_adr(REG_PRESCALE), 32'(presc), 4'hF);
		wb_write(word_adr(REG_CTRL), {24'h0, 3'(SLAVE_IDX), len, lsb, cpha, cpol}, 4'h1);
		cur_cpol  = cpol;
		cur_bits  = bits;
		cur_presc = presc;
		wb_write(word_adr(REG_TXDATA), data, 4'hF);
		start_cyc = cyc_cnt; // Start pulse sits in this ack cycle
		wb_read(word_adr(REG_STATUS), rd);
		expect_word("status busy", 32'(rd[STAT_BUSY]), 32'd1);
		wb_write(word_adr(REG_TXDATA), ~data, 4'hF); // Dropped while busy
		do begin
			wb_read(word_adr(REG_STATUS), rd);
		end while (!rd[STAT_DONE]);
		expect_word("status busy", 32'(rd[STAT_BUSY]), 32'd0);
		expect_word("slave rx", s_rx, data & mask);
		wb_read(word_adr(REG_RXDATA), rd);
		expect_word("rxdata", rd, reply & mask);
		wb_read(word_adr(REG_STATUS), rd);
		expect_word("status done", 32'(rd[STAT_DONE]), 32'd0);
		wb_read(word_adr(REG_TXDATA), rd);
		expect_word("txdata", rd, data);
	endtask

	// Pin monitor, sampled on the falling edge away from the DUT updates
	always @(negedge clk) begin
		if (!rst) begin
			gap++;
			if (&ss) begin
				expect_word("idle sck", 32'(sck), 32'(cur_cpol));
				expect_word("idle mosi", 32'(mosi), 32'd1);
			end else begin
				expect_word("ss", 32'(ss), 32'(SS_SEL));
			end
			if (prev_ss && !ss[SLAVE_IDX]) begin
				gap   = 0;
				edges = 0;
			end else if (!ss[SLAVE_IDX] && sck != prev_sck) begin
				expect_word("sck half period", gap, cur_presc + 1);
				gap = 0;
				edges++;
			end else if (!prev_ss && ss[SLAVE_IDX]) begin
				expect_word("closing half period", gap, cur_presc + 1);
				expect_word("sck edges", edges, 2 * cur_bits);
				expect_word("transfer clocks", cyc_cnt - start_cyc,
					(2 * cur_bits + 1) * (cur_presc + 1) + 1);
				xfers_seen++;
			end
			prev_ss  = ss[SLAVE_IDX];
			prev_sck = sck;
		end
	end

	initial begin
		logic [31:0] rd;
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		wb_sel   = '0;
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;

		wb_read(word_adr(REG_STATUS), rd);
		expect_word("status after reset", rd, 32'h0);
		wb_write(word_adr(REG_CTRL), 32'hFFFF_FF5A, 4'hF);
		wb_write(word_adr(REG_CTRL), 32'h0000_00A5, 4'hE); // Lane 0 off, no effect
		wb_read(word_adr(REG_CTRL), rd);
		expect_word("ctrl", rd, 32'h0000_005A);
		wb_write(word_adr(REG_PRESCALE), 32'hA5A5_A5A5, 4'b0101);
		wb_write(word_adr(REG_PRESCALE), 32'h5A5A_5A5A, 4'b1010);
		wb_read(word_adr(REG_PRESCALE), rd);
		expect_word("prescale", rd, 32'h00A5_5AA5); // Only 24 bits exist
		for (int a = 5; a < 8; a++) begin
			wb_read(SPI_ADDR_W'(a), rd);
			expect_word("unmapped read", rd, 32'h0);
		end

		run_transfer(1'b0, 1'b0, 1'b0, LEN_8, 1);
		run_transfer(1'b0, 1'b1, 1'b0, LEN_8, 1);
		run_transfer(1'b1, 1'b0, 1'b0, LEN_8, 1);
		run_transfer(1'b1, 1'b1, 1'b0, LEN_8, 1);
		run_transfer(1'b0, 1'b0, 1'b1, LEN_8, 2);
		run_transfer(1'b0, 1'b1, 1'b0, LEN_16, 0);
		run_transfer(1'b1, 1'b1, 1'b1, LEN_16, 3);
		run_transfer(1'b1, 1'b0, 1'b0, LEN_32, 1);
		run_transfer(1'b0, 1'b0, 1'b1, LEN_32, 2);
		repeat (2) @(posedge clk);
		expect_word("transfers seen", xfers_seen, NUM_XFERS);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog sized from the transfer count and the longest transfer
	initial begin
		#(NUM_XFERS * MAX_CLKS * 8 + 2000);
		$display("Watchdog timeout, a bus access or transfer never finished");
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Errors found");
		$finish;
	end

endmodule

// ==== verification/spi_slave_model.sv ====
`timescale 1ns/1ps

// Behavioral SPI slave for all four modes
// Sends a preset reply on miso and collects the mosi bits
module spi_slave_model (
	input  logic        ss_n,
	input  logic        sck,
	input  logic        mosi,
	output logic        miso,
	input  logic        cpol,
	input  logic        cpha,
	input  logic        lsb_first,
	input  logic [5:0]  bits,
	input  logic [31:0] reply,
	output logic [31:0] rx_word
);

	int tx_idx; // Next reply bit to send
	int rx_idx; // Next mosi bit to store

	// Word position of the n-th bit on the wire
	function automatic int bit_pos(input int n);
		return lsb_first ? n : int'(bits) - 1 - n;
	endfunction

	initial begin
		miso    = 1'b1;
		rx_word = '0;
		tx_idx  = 0;
		rx_idx  = 0;
	end

	always @(negedge ss_n) begin
		rx_word = '0; // Short words stay zero above the top bit
		rx_idx  = 0;
		if (cpha) begin
			tx_idx = 0; // First bit goes out on the leading edge
		end else begin
			miso   = reply[bit_pos(0)]; // Must be on the line before the first edge
			tx_idx = 1;
		end
	end

	always @(posedge ss_n)
		miso = 1'b1;

	// Leading edge samples in cpha 0, trailing edge in cpha 1
	always @(sck) begin
		if (!ss_n) begin
			if ((sck != cpol) != cpha) begin
				if (rx_idx < int'(bits))
					rx_word[bit_pos(rx_idx)] = mosi;
				rx_idx++;
			end else if (tx_idx < int'(bits)) begin
				miso = reply[bit_pos(tx_idx)];
				tx_idx++;
			end
		end
	end

endmodule

// ==== verilog/spi_master_top.sv ====
`timescale 1ns/1ps

// SPI master with a Wishbone classic host port
// Chain is regs -> divider -> engine, the top only wires them
module spi_master_top #(
	parameter int NUM_SS     = 4,
	parameter int PRESCALE_W = 24
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           wb_cyc,
	input  logic                           wb_stb,
	input  logic                           wb_we,
	input  logic [spi_pkg::SPI_ADDR_W-1:0] wb_adr,
	input  logic [31:0]                    wb_dat_i,
	input  logic [3:0]                     wb_sel,
	output logic [31:0]                    wb_dat_o,
	output logic                           wb_ack,
	output logic                           sck,
	output logic                           mosi,
	input  logic                           miso,
	output logic [NUM_SS-1:0]              ss
);
	import spi_pkg::*;

	// Register block outputs
	logic                      cpol;
	logic                      cpha;
	logic                      lsb_first;
	spi_len_e                  len;
	logic [$clog2(NUM_SS)-1:0] sel;
	logic [PRESCALE_W-1:0]     prescale;
	logic [31:0]               tx_word;
	logic                      start;

	// Engine and divider handshake
	logic        busy;
	logic        done_pulse;
	logic [31:0] rx_word;
	logic        div_run;
	logic        tick;

	spi_wb_regs #(
		.NUM_SS     (NUM_SS),
		.PRESCALE_W (PRESCALE_W)
	) u_regs (
		.clk        (clk),
		.rst        (rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_sel     (wb_sel),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack),
		.busy       (busy),
		.done_pulse (done_pulse),
		.rx_word    (rx_word),
		.cpol       (cpol),
		.cpha       (cpha),
		.lsb_first  (lsb_first),
		.len        (len),
		.sel        (sel),
		.prescale   (prescale),
		.tx_word    (tx_word),
		.start      (start)
	);

	spi_clk_div #(
		.PRESCALE_W (PRESCALE_W)
	) u_div (
		.clk      (clk),
		.rst      (rst),
		.run      (div_run),
		.prescale (prescale),
		.tick     (tick)
	);

	spi_shift_engine #(
		.NUM_SS (NUM_SS)
	) u_engine (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.cpol       (cpol),
		.cpha       (cpha),
		.lsb_first  (lsb_first),
		.len        (len),
		.sel        (sel),
		.tx_word    (tx_word),
		.tick       (tick),
		.miso       (miso),
		.div_run    (div_run),
		.busy       (busy),
		.done_pulse (done_pulse),
		.rx_word    (rx_word),
		.sck        (sck),
		.mosi       (mosi),
		.ss         (ss)
	);

endmodule

// ==== verilog/spi_shift_engine.sv ====
`timescale 1ns/1ps

// SPI transfer FSM
// Each tick is one sck edge, 2*bits edges then a closing tick that frees ss
module spi_shift_engine #(
	parameter int NUM_SS = 4
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  logic                      cpol,
	input  logic                      cpha,
	input  logic                      lsb_first,
	input  spi_pkg::spi_len_e         len,
	input  logic [$clog2(NUM_SS)-1:0] sel,
	input  logic [31:0]               tx_word,
	input  logic                      tick,
	input  logic                      miso,
	output logic                      div_run,
	output logic                      busy,
	output logic                      done_pulse,
	output logic [31:0]               rx_word,
	output logic                      sck,
	output logic                      mosi,
	output logic [NUM_SS-1:0]         ss
);
	import spi_pkg::*;

	// Settings latched at start
	logic        cpol_q;
	logic        cpha_q;
	logic        lsb_q;
	logic [5:0]  bits_q;

	logic [6:0]  edge_cnt;  // Edges done so far, up to 64
	logic [6:0]  edge_num;  // Number of the edge this tick makes
	logic        last_tick; // Closing tick after the final edge
	logic        sample_edge;
	logic        shift_edge;
	logic        sck_q;
	logic [31:0] tx_sr;
	logic [31:0] rx_sr;
	logic [5:0]  load_sh;
	logic [NUM_SS-1:0] ss_q; // All high outside a transfer

	assign div_run   = busy; // Divider runs for the whole transfer
	assign edge_num  = edge_cnt + 7'd1;
	assign last_tick = (edge_cnt == {bits_q, 1'b0});

	// Mode 0/2 samples on odd edges, mode 1/3 on even edges
	assign sample_edge = cpha_q ? !edge_num[0] : edge_num[0];
	// Edge 1 in mode 1/3 keeps the first bit already on mosi
	assign shift_edge  = cpha_q ? (edge_num[0] && (edge_cnt != 7'd0)) : !edge_num[0];

	// Shift needed to put an MSB-first word at the top of the register
	assign load_sh = 6'd32 - len_bits(len);

	// Outputs
	assign sck  = busy ? sck_q : cpol; // Rest level follows the control word
	assign mosi = busy ? (lsb_q ? tx_sr[0] : tx_sr[31]) : 1'b1;
	assign ss   = ss_q;

	// LSB-first data arrives at the top, move it down
	assign rx_word = lsb_q ? (rx_sr >> (6'd32 - bits_q)) : rx_sr;

	always_ff @(posedge clk) begin
		done_pulse <= 1'b0;
		if (rst) begin
			busy     <= 1'b0;
			edge_cnt <= '0;
			sck_q    <= 1'b0;
			ss_q     <= '1;
			cpol_q   <= 1'b0;
			cpha_q   <= 1'b0;
			lsb_q    <= 1'b0;
			bits_q   <= 6'd8;
		end else if (!busy) begin
			if (start) begin
				busy     <= 1'b1;
				edge_cnt <= '0;
				cpol_q   <= cpol;
				cpha_q   <= cpha;
				lsb_q    <= lsb_first;
				bits_q   <= len_bits(len);
				sck_q    <= cpol;
				for (int i = 0; i < NUM_SS; i++)
					ss_q[i] <= (i != sel); // Only the chosen slave goes low
			end
		end else if (tick) begin
			if (last_tick) begin
				busy       <= 1'b0; // Falls together with done_pulse
				done_pulse <= 1'b1;
				ss_q       <= '1;
				sck_q      <= cpol_q;
			end else begin
				edge_cnt <= edge_num;
				sck_q    <= !sck_q;
			end
		end
	end

	// Shift registers, loaded at start
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			tx_sr <= lsb_first ? tx_word : (tx_word << load_sh);
			rx_sr <= '0; // Short words come out zero-extended
		end else if (busy && tick && !last_tick) begin
			if (shift_edge)
				tx_sr <= lsb_q ? (tx_sr >> 1) : (tx_sr << 1);
			if (sample_edge)
				rx_sr <= lsb_q ? {miso, rx_sr[31:1]} : {rx_sr[30:0], miso};
		end
	end

	a_one_ss: assert property (@(posedge clk) disable iff (rst)
		$onehot0(~ss))
		else $error("More than one slave select low");

	// Slave select released by the cycle busy drops
	a_ss_in_busy: assert property (@(posedge clk) disable iff (rst)
		(ss != '1) |-> busy)
		else $error("Slave select low outside a transfer");

endmodule

// ==== verilog/spi_clk_div.sv ====
`timescale 1ns/1ps

// Half-period tick generator for the SPI engine
// One tick every prescale+1 clocks while run is high
module spi_clk_div #(
	parameter int PRESCALE_W = 24
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  run,
	input  logic [PRESCALE_W-1:0] prescale,
	output logic                  tick
);

	logic [PRESCALE_W-1:0] cnt; // Clocks into the current half period
	logic                  wrap;

	assign wrap = (cnt == prescale);
	assign tick = run && wrap; // Also high on the first cycle when prescale is 0

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (!run) begin
			cnt <= '0; // Idle, next run starts a full half period
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// A tick needs a run that began at least prescale clocks before,
	// unless the divider is bypassed
	a_tick_in_run: assert property (@(posedge clk) disable iff (rst)
		tick |-> run && ((prescale == '0) || $past(run)))
		else $error("Divider tick outside a running transfer");

endmodule

// ==== verilog/spi_wb_regs.sv ====
`timescale 1ns/1ps

// Wishbone classic register file for the SPI master
module spi_wb_regs #(
	parameter int NUM_SS     = 4,
	parameter int PRESCALE_W = 24
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [spi_pkg::SPI_ADDR_W-1:0] wb_adr,
	input  logic [31:0]                 wb_dat_i,
	input  logic [3:0]                  wb_sel,
	output logic [31:0]                 wb_dat_o,
	output logic                        wb_ack,
	input  logic                        busy,
	input  logic                        done_pulse,
	input  logic [31:0]                 rx_word,
	output logic                        cpol,
	output logic                        cpha,
	output logic                        lsb_first,
	output spi_pkg::spi_len_e           len,
	output logic [$clog2(NUM_SS)-1:0]   sel,
	output logic [PRESCALE_W-1:0]       prescale,
	output logic [31:0]                 tx_word,
	output logic                        start
);
	import spi_pkg::*;

	// Word indexes of the byte offsets
	localparam logic [SPI_ADDR_W-1:0] A_CTRL     = REG_CTRL[SPI_ADDR_W+1:2];
	localparam logic [SPI_ADDR_W-1:0] A_PRESCALE = REG_PRESCALE[SPI_ADDR_W+1:2];
	localparam logic [SPI_ADDR_W-1:0] A_TXDATA   = REG_TXDATA[SPI_ADDR_W+1:2];
	localparam logic [SPI_ADDR_W-1:0] A_RXDATA   = REG_RXDATA[SPI_ADDR_W+1:2];
	localparam logic [SPI_ADDR_W-1:0] A_STATUS   = REG_STATUS[SPI_ADDR_W+1:2];

	logic [7:0]  ctrl_q;  // Only byte lane 0 is implemented
	logic [31:0] rx_q;    // Last received word
	logic        done_q;  // Sticky done flag
	logic [31:0] rd_data;
	logic        req;
	logic        wr;
	logic        lock;

	// New request only, so the ack stays one cycle wide
	assign req  = wb_cyc && wb_stb && !wb_ack;
	assign wr   = req && wb_we;
	assign lock = busy || start; // Settings frozen from start to end of transfer

	// Control fields to the engine
	assign cpol      = ctrl_q[CTRL_CPOL];
	assign cpha      = ctrl_q[CTRL_CPHA];
	assign lsb_first = ctrl_q[CTRL_LSB];
	assign len       = spi_len_e'(ctrl_q[CTRL_LEN_LO +: 2]);
	assign sel       = ctrl_q[CTRL_SEL_LO +: $clog2(NUM_SS)];

	// Read mux, unmapped words read zero
	always_comb begin
		rd_data = '0;
		case (wb_adr)
			A_CTRL:     rd_data[7:0] = ctrl_q;
			A_PRESCALE: rd_data[PRESCALE_W-1:0] = prescale;
			A_TXDATA:   rd_data = tx_word;
			A_RXDATA:   rd_data = rx_q;
			A_STATUS: begin
				rd_data[STAT_BUSY] = lock; // Reads busy right after the TXDATA write
				rd_data[STAT_DONE] = done_q;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			start    <= 1'b0;
			ctrl_q   <= '0;
			prescale <= '0;
			tx_word  <= '0;
			rx_q     <= '0;
			done_q   <= 1'b0;
		end else begin
			wb_ack <= req; // Ack in the cycle after the request
			start  <= wr && (wb_adr == A_TXDATA) && !lock;

			if (wr && (wb_adr == A_CTRL) && !lock && wb_sel[0])
				ctrl_q <= wb_dat_i[7:0];

			// Byte enables per prescale bit
			if (wr && (wb_adr == A_PRESCALE) && !lock) begin
				for (int i = 0; i < PRESCALE_W; i++)
					if (wb_sel[i/8])
						prescale[i] <= wb_dat_i[i];
			end

			// TXDATA while busy is acked and dropped
			if (wr && (wb_adr == A_TXDATA) && !lock) begin
				for (int b = 0; b < 4; b++)
					if (wb_sel[b])
						tx_word[8*b +: 8] <= wb_dat_i[8*b +: 8];
			end

			if (done_pulse)
				rx_q <= rx_word; // Engine word valid only with the pulse

			if (done_pulse)
				done_q <= 1'b1;
			else if (req && !wb_we && (wb_adr == A_RXDATA))
				done_q <= 1'b0; // Cleared by reading the data
		end
	end

	// Read data lands in the ack cycle
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_o <= rd_data;
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without a cyc and stb request");

endmodule

// ==== verilog/spi_pkg.sv ====
// Shared register map and control word layout for the SPI master
package spi_pkg;

	// Wishbone word address width, covers five registers
	localparam int SPI_ADDR_W = 3;

	// Byte offsets of the registers
	localparam logic [7:0] REG_CTRL     = 8'h00; // Mode, order, length, select
	localparam logic [7:0] REG_PRESCALE = 8'h04; // Half-period divider
	localparam logic [7:0] REG_TXDATA   = 8'h08; // Write starts a transfer
	localparam logic [7:0] REG_RXDATA   = 8'h0C; // Read clears done
	localparam logic [7:0] REG_STATUS   = 8'h10; // Busy and done flags

	// Control word bit positions
	localparam int CTRL_CPOL   = 0; // Idle level of sck
	localparam int CTRL_CPHA   = 1; // Sample on second edge when set
	localparam int CTRL_LSB    = 2; // LSB first when set
	localparam int CTRL_LEN_LO = 3; // Length field, bits 4:3
	localparam int CTRL_SEL_LO = 5; // Slave select field, bits 7:5

	// Status word bit positions
	localparam int STAT_BUSY = 0;
	localparam int STAT_DONE = 1;

	// Transfer length codes
	typedef enum logic [1:0] {
		LEN_8  = 2'd0,
		LEN_16 = 2'd1,
		LEN_32 = 2'd2
	} spi_len_e;

	// Bit count of a length code; code 3 falls through to 32 bits
	function automatic logic [5:0] len_bits(input spi_len_e len);
		case (len)
			LEN_8:   return 6'd8;
			LEN_16:  return 6'd16;
			default: return 6'd32;
		endcase
	endfunction

endpackage
